/* source/uart_pkg.sv */
/*
    Shared constants for the serial receiver: baud rate table, frame layout
    and the 16x oversampling points used by the bit sampling logic.
    Blocks refer to these with scoped names, e.g. uart_pkg::mid_sample.
*/
`default_nettype none

package uart_pkg;

    localparam int oversample = 16;   // sample ticks per bit
    localparam int data_bits  = 8;

    typedef logic [2:0] baud_sel_t;

    // indexed by baud_select
    localparam int baud_table [8] = '{
        300,
        1200,
        2400,
        4800,
        9600,
        19200,
        57600,
        115200
    };

    // positions inside a bit, in sample ticks counted from the bit start
    localparam logic [3:0] mid_sample     = 4'd8;
    localparam logic [3:0] edge_window_lo = 4'd4;   // edges after this tick are suspicious
    localparam logic [3:0] edge_window_hi = 4'd12;  // up to and including this one

    // clock cycles per sample tick, rounded down and never below one
    function automatic int baud_divisor(int clk_freq, baud_sel_t sel);
        int div;
        div = clk_freq / (oversample * baud_table[sel]);
        if (div < 1) begin
            div = 1;
        end
        return div;
    endfunction

endpackage

`default_nettype wire

/* source/baud_tick_gen.sv */
/*
    Sample tick generator. Divides clk down to 16x the selected baud rate
    and emits a one-cycle sample_tick each period. A baud_restart reloads
    the divider so the ticks line up with a detected start edge.
*/
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int clk_freq_hz = 10_000_000
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire uart_pkg::baud_sel_t baud_select,
    input  wire                   baud_restart,
    output logic                  sample_tick
);

    logic [31:0] div_table [8];   // cycles per tick, one per table rate
    logic [31:0] reload;
    logic [31:0] count;

    // divisors are fixed at elaboration from the package rate table
    for (genvar i = 0; i < 8; i++) begin : g_div
        localparam int div_i = uart_pkg::baud_divisor(clk_freq_hz, 3'(i));
        assign div_table[i] = 32'(div_i);
    end

    assign reload = div_table[baud_select] - 32'd1;

    assign sample_tick = (count == 32'd0);   // expires once per period

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= 32'd0;
        end else if (baud_restart) begin
            count <= reload;   // first tick one full period after the edge
        end else if (count == 32'd0) begin
            count <= reload;
        end else begin
            count <= count - 32'd1;
        end
    end

endmodule

`default_nettype wire

/* source/rx_line_sampler.sv */
/*
    Conditions the raw serial input. rxd goes through a two-flop
    synchroniser, then a filter that only accepts a new level after
    filter_len equal samples. line_edge pulses for one clock whenever
    the filtered level line_filt changes.
*/
`timescale 1ns/1ps
`default_nettype none

module rx_line_sampler #(
    parameter int filter_len = 4
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  rxd,
    output logic line_filt,
    output logic line_edge
);

    localparam int cnt_w = (filter_len > 1) ? $clog2(filter_len + 1) : 1;

    logic             sync_0;
    logic             sync_1;
    logic [cnt_w-1:0] stable_cnt;   // samples seen at the new level

    // synchroniser, idles high like the line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_0 <= 1'b1;
            sync_1 <= 1'b1;
        end else begin
            sync_0 <= rxd;
            sync_1 <= sync_0;
        end
    end

    // glitch filter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stable_cnt <= '0;
            line_filt  <= 1'b1;
            line_edge  <= 1'b0;
        end else begin
            line_edge <= 1'b0;
            if (sync_1 == line_filt) begin
                stable_cnt <= '0;   // short excursion ends, start over
            end else if (stable_cnt == cnt_w'(filter_len - 1)) begin
                // the new level held long enough
                stable_cnt <= '0;
                line_filt  <= sync_1;
                line_edge  <= 1'b1;   // same cycle as the new level
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/uart_frame_receiver.sv */
/*
    Frame FSM for one start bit, eight data bits LSB first, even parity
    and one stop bit. Bits are read at the middle sample tick; an edge in
    the middle half of a data or parity bit aborts with a framing error.
    Any delivered error parks the FSM in lock until rx_en goes low.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_frame_receiver (
    input  wire        clk,
    input  wire        reset,
    input  wire        rx_en,
    input  wire        sample_tick,
    input  wire        line_filt,
    input  wire        line_edge,
    output logic       baud_restart,
    output logic       frame_done,
    output logic [7:0] frame_data,
    output logic       frame_ferror,
    output logic       frame_perror
);

    localparam logic [2:0] st_disabled = 3'd0;
    localparam logic [2:0] st_idle     = 3'd1;
    localparam logic [2:0] st_start    = 3'd2;
    localparam logic [2:0] st_data     = 3'd3;
    localparam logic [2:0] st_parity   = 3'd4;
    localparam logic [2:0] st_stop     = 3'd5;
    localparam logic [2:0] st_lock     = 3'd6;

    localparam logic [2:0] last_bit = 3'(uart_pkg::data_bits - 1);

    logic [2:0] state;
    logic [3:0] tick_cnt;   // number of the next tick within the bit, 0 means 16
    logic [2:0] bit_cnt;    // data bit being received
    logic       mid_tick;
    logic       end_tick;
    logic       in_window;
    logic       unstable;

    assign mid_tick  = sample_tick && (tick_cnt == uart_pkg::mid_sample);
    assign end_tick  = sample_tick && (tick_cnt == 4'd0);   // 16th tick closes the bit
    assign in_window = (tick_cnt > uart_pkg::edge_window_lo) &&
                       (tick_cnt <= uart_pkg::edge_window_hi);
    assign unstable  = line_edge && in_window &&
                       ((state == st_data) || (state == st_parity));

    // falling edge while waiting for a frame
    assign baud_restart = (state == st_idle) && rx_en && line_edge && !line_filt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= st_disabled;
            tick_cnt     <= 4'd0;
            bit_cnt      <= 3'd0;
            frame_done   <= 1'b0;
            frame_ferror <= 1'b0;
            frame_perror <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (sample_tick) begin
                tick_cnt <= tick_cnt + 4'd1;
            end
            case (state)
                st_disabled: begin
                    if (rx_en) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    if (!rx_en) begin
                        state <= st_disabled;
                    end else if (baud_restart) begin
                        state        <= st_start;
                        tick_cnt     <= 4'd1;   // divider restarts in step
                        bit_cnt      <= 3'd0;
                        frame_ferror <= 1'b0;
                        frame_perror <= 1'b0;
                    end
                end
                st_start: begin
                    if (!rx_en) begin
                        state <= st_disabled;
                    end else if (mid_tick && line_filt) begin
                        state <= st_idle;   // false start, drop quietly
                    end else if (end_tick) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (!rx_en) begin
                        state <= st_disabled;
                    end else if (unstable) begin
                        frame_done   <= 1'b1;
                        frame_ferror <= 1'b1;
                        state        <= st_lock;
                    end else if (end_tick) begin
                        if (bit_cnt == last_bit) begin
                            state <= st_parity;
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end
                st_parity: begin
                    if (!rx_en) begin
                        state <= st_disabled;
                    end else if (unstable) begin
                        frame_done   <= 1'b1;
                        frame_ferror <= 1'b1;
                        state        <= st_lock;
                    end else begin
                        if (mid_tick) begin
                            frame_perror <= (line_filt != ^frame_data);   // even parity
                        end
                        if (end_tick) begin
                            state <= st_stop;
                        end
                    end
                end
                st_stop: begin
                    if (!rx_en) begin
                        state <= st_disabled;
                    end else if (mid_tick) begin
                        frame_done   <= 1'b1;
                        frame_ferror <= !line_filt;   // stop bit must be high
                        state        <= (!line_filt || frame_perror) ? st_lock : st_idle;
                    end
                end
                st_lock: begin
                    if (!rx_en) begin
                        state <= st_disabled;
                    end
                end
                default: state <= st_disabled;
            endcase
        end
    end

    // data shift register, LSB arrives first
    always_ff @(posedge clk) begin
        if ((state == st_data) && mid_tick) begin
            frame_data <= {line_filt, frame_data[7:1]};
        end
    end

endmodule

`default_nettype wire

/* source/uart_rx_top.sv */
/*
    Serial receiver top level. Joins the tick generator, line sampler and
    frame FSM and holds one received byte behind a valid/ready handshake.
    A frame finishing while the held byte is unaccepted is dropped and
    sets rx_overrun until the next transfer.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top #(
    parameter int clk_freq_hz = 10_000_000,
    parameter int filter_len  = 4
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire uart_pkg::baud_sel_t baud_select,
    input  wire                      rx_en,
    input  wire                      rxd,
    input  wire                      rx_ready,
    output logic [7:0]               rx_data,
    output logic                     rx_ferror,
    output logic                     rx_perror,
    output logic                     rx_overrun,
    output logic                     rx_valid
);

    logic       sample_tick;
    logic       baud_restart;
    logic       line_filt;
    logic       line_edge;
    logic       frame_done;
    logic [7:0] frame_data;
    logic       frame_ferror;
    logic       frame_perror;
    logic       xfer;
    logic       load;

    baud_tick_gen #(
        .clk_freq_hz(clk_freq_hz)
    ) u_baud (
        .clk         (clk),
        .reset       (reset),
        .baud_select (baud_select),
        .baud_restart(baud_restart),
        .sample_tick (sample_tick)
    );

    rx_line_sampler #(
        .filter_len(filter_len)
    ) u_sampler (
        .clk      (clk),
        .reset    (reset),
        .rxd      (rxd),
        .line_filt(line_filt),
        .line_edge(line_edge)
    );

    uart_frame_receiver u_frame (
        .clk         (clk),
        .reset       (reset),
        .rx_en       (rx_en),
        .sample_tick (sample_tick),
        .line_filt   (line_filt),
        .line_edge   (line_edge),
        .baud_restart(baud_restart),
        .frame_done  (frame_done),
        .frame_data  (frame_data),
        .frame_ferror(frame_ferror),
        .frame_perror(frame_perror)
    );

    assign xfer = rx_valid && rx_ready;
    assign load = frame_done && (!rx_valid || rx_ready);   // slot free or freed now

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_valid   <= 1'b0;
            rx_ferror  <= 1'b0;
            rx_perror  <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            if (load) begin
                rx_valid  <= 1'b1;
                rx_ferror <= frame_ferror;
                rx_perror <= frame_perror;
            end else if (xfer) begin
                rx_valid <= 1'b0;
            end
            if (xfer) begin
                rx_overrun <= 1'b0;
            end else if (frame_done && rx_valid) begin
                rx_overrun <= 1'b1;   // frame lost, byte held
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rx_data <= frame_data;
        end
    end

endmodule

`default_nettype wire

/* include/uart_tb_defs.svh */
/*
    Constants and stimulus table for the serial receiver testbench.
    Included inside the testbench module; rows are applied in order.
*/
`ifndef UART_TB_DEFS_SVH
`define UART_TB_DEFS_SVH

localparam int tb_clk_period_ns = 100;
localparam int tb_clk_freq_hz   = 10_000_000;
localparam int tb_filter_len    = 4;
localparam int tb_timeout_bits  = 14;            // wait limit in bit periods
localparam int tb_glitch_cycles = 2;             // shorter than the filter
localparam int tb_pulse_cycles  = tb_filter_len + 6;   // mid-bit pulse longer than the filter
localparam logic [31:0] tb_seed = 32'hef22_8b92;

// row kinds
localparam logic [1:0] tb_kind_frame       = 2'd0;   // full frame
localparam logic [1:0] tb_kind_glitch      = 2'd1;   // short low pulse on idle line
localparam logic [1:0] tb_kind_short_start = 2'd2;   // start bit ends before its middle

typedef struct packed {
    logic [1:0] kind;
    logic       unlock;       // pulse rx_en low one cycle before the row
    logic [2:0] baud_select;
    logic [7:0] data;
    logic       random;       // data and exp_data replaced by $urandom
    logic       parity_bad;
    logic       stop_low;
    int         glitch_bit;   // data bit with a mid-bit pulse or -1
    logic       rx_en;
    int         ready_hold;   // frames sent with rx_ready held low
    logic       exp_delivered;
    logic [7:0] exp_data;
    logic       exp_ferror;
    logic       exp_perror;
    logic       exp_overrun;
} stim_row_t;

localparam int tb_num_rows = 17;

localparam stim_row_t stim_table [tb_num_rows] = '{
    '{2'd0, 1'b0, 3'd4, 8'ha5, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b1, 8'ha5, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd6, 8'h00, 1'b1, 1'b0, 1'b0, -1, 1'b1, 0, 1'b1, 8'h00, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd7, 8'h00, 1'b1, 1'b0, 1'b0, -1, 1'b1, 0, 1'b1, 8'h00, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd7, 8'h3c, 1'b0, 1'b1, 1'b0, -1, 1'b1, 0, 1'b1, 8'h3c, 1'b0, 1'b1, 1'b0},
    '{2'd0, 1'b0, 3'd7, 8'h55, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b1, 3'd7, 8'h0f, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b1, 8'h0f, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd4, 8'h81, 1'b0, 1'b0, 1'b1, -1, 1'b1, 0, 1'b1, 8'h81, 1'b1, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd4, 8'h5a, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b1, 3'd6, 8'h7e, 1'b0, 1'b0, 1'b0, 3, 1'b1, 0, 1'b1, 8'h7e, 1'b1, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd6, 8'h24, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b1, 3'd6, 8'h42, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b1, 8'h42, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd7, 8'h11, 1'b0, 1'b0, 1'b0, -1, 1'b1, 2, 1'b1, 8'h11, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd7, 8'h22, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b1, 8'h11, 1'b0, 1'b0, 1'b1},
    '{2'd1, 1'b0, 3'd7, 8'h00, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
    '{2'd2, 1'b0, 3'd4, 8'h00, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd7, 8'h99, 1'b0, 1'b0, 1'b0, -1, 1'b0, 0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
    '{2'd0, 1'b0, 3'd4, 8'hc3, 1'b0, 1'b0, 1'b0, -1, 1'b1, 0, 1'b1, 8'hc3, 1'b0, 1'b0, 1'b0}
};

`endif

/* testbench/tb_uart_rx.sv */
/*
    Testbench for the serial receiver top level. Applies the stimulus table
    from uart_tb_defs.svh row by row. Each row drives the serial line while
    a second branch waits for the output handshake and checks the results.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_uart_rx;

    `include "uart_tb_defs.svh"

    localparam int drive_delay = 10;   // ns after the rising edge
    localparam int row_gap     = 32;   // idle cycles between rows

    logic       clk;
    logic       reset;
    logic [2:0] baud_select;
    logic       rx_en;
    logic       rxd;
    logic       rx_ready;
    logic [7:0] rx_data;
    logic       rx_ferror;
    logic       rx_perror;
    logic       rx_overrun;
    logic       rx_valid;

    uart_rx_top #(
        .clk_freq_hz(tb_clk_freq_hz),
        .filter_len (tb_filter_len)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .baud_select(baud_select),
        .rx_en      (rx_en),
        .rxd        (rxd),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data),
        .rx_ferror  (rx_ferror),
        .rx_perror  (rx_perror),
        .rx_overrun (rx_overrun),
        .rx_valid   (rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(tb_clk_period_ns / 2) clk = ~clk;
    end

    // clock cycles per serial bit at the selected table rate
    function automatic int bit_cycles(input logic [2:0] sel);
        int div;
        div = tb_clk_freq_hz / (uart_pkg::oversample * uart_pkg::baud_table[sel]);
        return uart_pkg::oversample * div;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopped on failure");
    endtask

    // returns 10 ns after a rising edge from any starting time
    task automatic step(input int cycles);
        repeat (cycles) @(posedge clk);
        #(drive_delay);
    endtask

    task automatic drive_bit(input logic value, input int cycles);
        rxd = value;
        step(cycles);
    endtask

    task automatic send_frame(input logic [2:0] sel, input logic [7:0] data,
                              input logic parity_bad, input logic stop_low,
                              input int glitch_bit);
        int         n;
        int         lead;
        int         i;
        logic [7:0] shift;
        logic       par;
        n     = bit_cycles(sel);
        lead  = n / 2 - tb_pulse_cycles / 2;   // pulse centred on the bit middle
        shift = data;
        par   = (^data) ^ parity_bad;          // even parity unless the row corrupts it
        drive_bit(1'b0, n);
        for (i = 0; i < 8; i++) begin
            if (i == glitch_bit) begin
                drive_bit(shift[0], lead);
                drive_bit(!shift[0], tb_pulse_cycles);
                drive_bit(shift[0], n - lead - tb_pulse_cycles);
            end else begin
                drive_bit(shift[0], n);
            end
            shift = shift >> 1;
        end
        drive_bit(par, n);
        drive_bit(!stop_low, n);
        rxd = 1'b1;
    endtask

    task automatic drive_row(input stim_row_t row);
        case (row.kind)
            tb_kind_glitch: begin
                drive_bit(1'b0, tb_glitch_cycles);
                rxd = 1'b1;
            end
            tb_kind_short_start: begin
                drive_bit(1'b0, bit_cycles(row.baud_select) / 4);   // back high early
                rxd = 1'b1;
            end
            tb_kind_frame: begin
                send_frame(row.baud_select, row.data, row.parity_bad, row.stop_low,
                           row.glitch_bit);
            end
            default: begin
                report_failure($sformatf("unknown kind %0d in a stimulus row", row.kind));
            end
        endcase
    endtask

    // waits for a new byte or for overrun when a byte is already held
    task automatic collect_output(input int idx, input stim_row_t row);
        int   limit;
        int   count;
        logic held;
        logic seen;
        limit = tb_timeout_bits * bit_cycles(row.baud_select);
        held  = rx_valid;
        count = 0;
        seen  = 1'b0;
        while (!seen && count < limit) begin
            @(negedge clk);
            count++;
            if (held) begin
                seen = rx_overrun;
            end else begin
                seen = rx_valid;
            end
        end
        if (!row.exp_delivered) begin
            check_value($sformatf("rx_valid (row %0d)", idx), 32'(seen), 32'(1'b0));
        end else if (!seen) begin
            report_failure($sformatf("timeout: no %s within %0d clock cycles on row %0d",
                                     held ? "rx_overrun" : "rx_valid", limit, idx));
        end else begin
            check_value($sformatf("rx_valid (row %0d)", idx), 32'(rx_valid), 32'(1'b1));
            if (!row.exp_ferror) begin
                check_value($sformatf("rx_data (row %0d)", idx), 32'(rx_data),
                            32'(row.exp_data));
            end
            check_value($sformatf("rx_ferror (row %0d)", idx), 32'(rx_ferror),
                        32'(row.exp_ferror));
            check_value($sformatf("rx_perror (row %0d)", idx), 32'(rx_perror),
                        32'(row.exp_perror));
            check_value($sformatf("rx_overrun (row %0d)", idx), 32'(rx_overrun),
                        32'(row.exp_overrun));
            if (!held && rx_ready) begin
                @(negedge clk);   // one transfer only
                check_value($sformatf("rx_valid after transfer (row %0d)", idx),
                            32'(rx_valid), 32'(1'b0));
            end
        end
    endtask

    initial begin
        int          i;
        int          ready_left;
        stim_row_t   row;

        reset       = 1'b1;
        baud_select = 3'd4;
        rx_en       = 1'b1;
        rxd         = 1'b1;
        rx_ready    = 1'b1;
        ready_left  = 0;
        void'($urandom(tb_seed));

        repeat (3) @(posedge clk);
        #(drive_delay);
        reset = 1'b0;
        @(negedge clk);
        check_value("rx_valid after reset", 32'(rx_valid), 32'(1'b0));
        check_value("rx_ferror after reset", 32'(rx_ferror), 32'(1'b0));
        check_value("rx_perror after reset", 32'(rx_perror), 32'(1'b0));
        check_value("rx_overrun after reset", 32'(rx_overrun), 32'(1'b0));
        step(4);

        for (i = 0; i < tb_num_rows; i++) begin
            row = stim_table[i];
            if (row.random) begin
                row.data     = 8'($urandom);
                row.exp_data = row.data;
            end
            if (row.unlock) begin
                rx_en = 1'b0;   // leaves the lock state
                step(1);
            end
            rx_en       = row.rx_en;
            baud_select = row.baud_select;
            if (row.ready_hold > 0 && ready_left == 0) begin
                rx_ready   = 1'b0;
                ready_left = row.ready_hold;
            end
            step(4);

            fork
                drive_row(row);
                collect_output(i, row);
            join
            step(row_gap);

            if (ready_left > 0) begin
                ready_left--;
                if (ready_left == 0) begin
                    rx_ready = 1'b1;
                    @(posedge clk);
                    @(negedge clk);
                    check_value("rx_valid after held transfer", 32'(rx_valid), 32'(1'b0));
                    check_value("rx_overrun after held transfer", 32'(rx_overrun),
                                32'(1'b0));
                    step(1);
                end
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* uart_rx_top.f */
+incdir+include
source/uart_pkg.sv
source/baud_tick_gen.sv
source/rx_line_sampler.sv
source/uart_frame_receiver.sv
source/uart_rx_top.sv
testbench/tb_uart_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the serial receiver testbench with Verilator and runs it.
# The run passes only if the pass message shows up in the simulation log.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

rm -rf obj_dir "$build_log" "$sim_log"

verilator --binary --timing -f uart_rx_top.f --top-module tb_uart_rx \
    -o sim_uart_rx > "$build_log" 2>&1 \
    || { cat "$build_log"; echo "build failed"; exit 1; }

./obj_dir/sim_uart_rx > "$sim_log" 2>&1
cat "$sim_log"

grep -q "^Test OK$" "$sim_log" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
